/* source/arena_pkg.sv */
`default_nettype none

package arena_pkg;

	// Coprocessor select on address bits 11:7
	typedef enum logic [4:0] {
		SEL_POS_P1    = 5'd0,
		SEL_POS_P2    = 5'd1,
		SEL_CTRL_P1   = 5'd4,
		SEL_CTRL_P2   = 5'd5,
		SEL_SIZE_P1   = 5'd8,
		SEL_SIZE_P2   = 5'd9,
		SEL_COLL_P1   = 5'd12,
		SEL_COLL_P2   = 5'd13,
		SEL_ATTACK_P1 = 5'd16,
		SEL_ATTACK_P2 = 5'd17,
		SEL_DAMAGE_P1 = 5'd18,
		SEL_DAMAGE_P2 = 5'd19,
		SEL_STEP      = 5'd24
	} coproc_sel_t;

	typedef enum logic [1:0] {ATK_IDLE, ATK_ACTIVE, ATK_RECOVER} attack_state_t;

	// Controller word bits
	localparam int CTRL_LEFT = 0;
	localparam int CTRL_RIGHT = 1;
	localparam int CTRL_JUMP = 2;
	localparam int CTRL_ATTACK = 3;

	localparam int ATK_HIT_BIT = 0;
	localparam int ATK_FREEZE_BIT = 11;

	localparam int COLL_FLOOR = 0;
	localparam int COLL_CEILING = 1;
	localparam int COLL_LEFT = 2;
	localparam int COLL_RIGHT = 3;

	localparam logic signed [31:0] GRAVITY = 32'sd1;
	localparam logic signed [31:0] JUMP_VEL = -32'sd8;
	localparam logic signed [31:0] RUN_SPEED = 32'sd4;
	localparam logic signed [31:0] KNOCK_SPEED = 32'sd6;
	localparam logic [31:0] DAMAGE_PER_HIT = 32'd7;
	localparam logic [31:0] DAMAGE_MAX = 32'd999;

	// Packed as {x, y} with y growing downward
	localparam logic [31:0] STAGE_POS = {16'd40, 16'd200};
	localparam logic [31:0] STAGE_SIZE = {16'd400, 16'd40};
	localparam logic [31:0] START_POS_P1 = {16'd100, 16'd150};
	localparam logic [31:0] START_POS_P2 = {16'd300, 16'd150};

endpackage

`default_nettype wire

/* source/data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module data_memory #(
	parameter int DMEM_ADDR_BITS = 12
) (
	input  logic                      clock,
	input  logic [DMEM_ADDR_BITS-1:0] address,
	input  logic [31:0]               data,
	input  logic                      wren,
	output logic [31:0]               q
);

	localparam int DEPTH = 1 << DMEM_ADDR_BITS;

	logic [31:0] mem [0:DEPTH-1];

	// Read returns the old word on a same-cycle write
	always_ff @(posedge clock) begin
		if (wren) begin
			mem[address] <= data;
		end
	end

	always_ff @(posedge clock) begin
		q <= mem[address]; // Registered read port
	end

endmodule

`default_nettype wire

/* source/physics_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module physics_unit import arena_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        step,
	input  logic [31:0] start_pos,
	input  logic [31:0] controls,
	input  logic [31:0] knockback,
	input  logic        frozen,
	input  logic        on_floor,
	output logic [31:0] position
);

	logic signed [15:0] pos_x;
	logic signed [15:0] pos_y;
	logic signed [15:0] vel_y;

	logic signed [15:0] run_dx;
	logic signed [15:0] knock_dx;
	logic signed [15:0] next_vel;
	logic               go_left;
	logic               go_right;
	logic               jump;

	assign go_left = controls[CTRL_LEFT];
	assign go_right = controls[CTRL_RIGHT];
	assign jump = controls[CTRL_JUMP];

	// Only the x half of the knockback word carries motion
	assign knock_dx = $signed(knockback[15:0]);

	always_comb begin
		run_dx = 16'sd0; // Both or neither held
		if (go_right && !go_left) begin
			run_dx = $signed(RUN_SPEED[15:0]);
		end else if (go_left && !go_right) begin
			run_dx = -$signed(RUN_SPEED[15:0]);
		end
	end

	always_comb begin
		if (on_floor && jump) begin
			next_vel = $signed(JUMP_VEL[15:0]);
		end else if (on_floor && vel_y >= 16'sd0) begin
			next_vel = 16'sd0; // Landed on the floor
		end else begin
			next_vel = vel_y + $signed(GRAVITY[15:0]);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pos_x <= $signed(start_pos[31:16]);
			pos_y <= $signed(start_pos[15:0]);
			vel_y <= 16'sd0;
		end else if (step && !frozen) begin
			pos_x <= pos_x + run_dx + knock_dx;
			vel_y <= next_vel;
			pos_y <= pos_y + next_vel; // New velocity applies this step
		end
	end

	assign position = {pos_x, pos_y};

	// Hub only raises step out of reset
	assert property (@(posedge clock) !(reset && step))
		else $error("physics_unit: step during reset");

endmodule

`default_nettype wire

/* source/collision_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module collision_unit import arena_pkg::*; (
	input  logic [31:0] player_pos,
	input  logic [31:0] player_size,
	input  logic [31:0] stage_pos,
	input  logic [31:0] stage_size,
	output logic [3:0]  coll
);

	// One extra bit so edge sums never wrap
	logic signed [16:0] p_left, p_right, p_top, p_bottom;
	logic signed [16:0] s_left, s_right, s_top, s_bottom;
	logic               x_overlap;
	logic               y_overlap;

	assign p_left = $signed(player_pos[31:16]);
	assign p_top = $signed(player_pos[15:0]);
	assign p_right = p_left + $signed({1'b0, player_size[31:16]});
	assign p_bottom = p_top + $signed({1'b0, player_size[15:0]});

	assign s_left = $signed(stage_pos[31:16]);
	assign s_top = $signed(stage_pos[15:0]);
	assign s_right = s_left + $signed({1'b0, stage_size[31:16]});
	assign s_bottom = s_top + $signed({1'b0, stage_size[15:0]});

	assign x_overlap = (p_left < s_right) && (p_right > s_left);
	assign y_overlap = (p_top < s_bottom) && (p_bottom > s_top);

	// Standing on or sunk into the top surface
	assign coll[COLL_FLOOR] = x_overlap && (p_bottom >= s_top) && (p_top < s_top);
	assign coll[COLL_CEILING] = x_overlap && (p_top <= s_bottom) && (p_bottom > s_bottom);

	// Side contact while vertically inside the stage band
	assign coll[COLL_LEFT] = y_overlap && (p_right >= s_left) && (p_left < s_left);
	assign coll[COLL_RIGHT] = y_overlap && (p_left <= s_right) && (p_right > s_right);

endmodule

`default_nettype wire

/* source/attack_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module attack_unit import arena_pkg::*; #(
	parameter int ATTACK_STEPS = 3
) (
	input  logic        clock,
	input  logic        reset,
	input  logic        step,
	input  logic [31:0] controls,
	input  logic [31:0] own_pos,
	input  logic [31:0] own_size,
	input  logic [31:0] foe_pos,
	input  logic [31:0] foe_size,
	output logic [31:0] attack,
	output logic [31:0] knockback
);

	localparam int CNT_W = (ATTACK_STEPS > 1) ? $clog2(ATTACK_STEPS) : 1;

	attack_state_t      state;
	logic [CNT_W-1:0]   step_cnt;
	logic signed [16:0] own_l, own_r, own_t, own_b;
	logic signed [16:0] foe_l, foe_r, foe_t, foe_b;
	logic               overlap;
	logic               active;
	logic               hit;

	assign own_l = $signed(own_pos[31:16]);
	assign own_t = $signed(own_pos[15:0]);
	assign own_r = own_l + $signed({1'b0, own_size[31:16]});
	assign own_b = own_t + $signed({1'b0, own_size[15:0]});
	assign foe_l = $signed(foe_pos[31:16]);
	assign foe_t = $signed(foe_pos[15:0]);
	assign foe_r = foe_l + $signed({1'b0, foe_size[31:16]});
	assign foe_b = foe_t + $signed({1'b0, foe_size[15:0]});

	assign overlap = (own_l < foe_r) && (own_r > foe_l) && (own_t < foe_b) && (own_b > foe_t);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ATK_IDLE;
			step_cnt <= '0;
		end else if (step) begin
			case (state)
				ATK_IDLE: if (controls[CTRL_ATTACK]) begin
					state <= ATK_ACTIVE;
					step_cnt <= '0;
				end
				ATK_ACTIVE: if (step_cnt == CNT_W'(ATTACK_STEPS - 1)) begin
					state <= ATK_RECOVER;
				end else begin
					step_cnt <= step_cnt + 1'b1;
				end
				default: state <= ATK_IDLE; // Recover lasts one step
			endcase
		end
	end

	assign active = (state == ATK_ACTIVE);
	assign hit = active && overlap;

	always_comb begin
		attack = '0;
		attack[ATK_FREEZE_BIT] = active;
		attack[ATK_HIT_BIT] = hit;
	end

	// Push the foe away from the attacker
	assign knockback = !hit ? 32'd0 : (foe_l > own_l) ? KNOCK_SPEED : -KNOCK_SPEED;

	assert property (@(posedge clock) disable iff (reset)
		state inside {ATK_IDLE, ATK_ACTIVE, ATK_RECOVER})
		else $error("attack_unit: illegal state");

	// Hit window stays inside the active phase and its step count
	assert property (@(posedge clock) disable iff (reset)
		attack[ATK_HIT_BIT] |-> (state == ATK_ACTIVE) && (int'(step_cnt) < ATTACK_STEPS))
		else $error("attack_unit: hit outside active phase");

endmodule

`default_nettype wire

/* source/damage_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module damage_unit import arena_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        hit,
	output logic [31:0] damage
);

	logic        hit_q;     // Previous hit level for edge detect
	logic [31:0] damage_sum;

	assign damage_sum = damage + DAMAGE_PER_HIT;

	always_ff @(posedge clock) begin
		if (reset) begin
			hit_q <= 1'b0;
			damage <= '0;
		end else begin
			hit_q <= hit;
			if (hit && !hit_q) begin
				damage <= (damage_sum > DAMAGE_MAX) ? DAMAGE_MAX : damage_sum;
			end
		end
	end

	assert property (@(posedge clock) disable iff (reset) damage <= DAMAGE_MAX)
		else $error("damage_unit: damage above limit");

endmodule

`default_nettype wire

/* source/mmio_hub.sv */
`timescale 1ns/1ps
`default_nettype none

module mmio_hub import arena_pkg::*; #(
	parameter int DMEM_ADDR_BITS = 12,
	parameter int ATTACK_STEPS = 3
) (
	input  logic        clock,
	input  logic        reset,
	input  logic [12:0] address,
	input  logic [31:0] data_in,
	input  logic        wren,
	output logic [31:0] data_out
);

	coproc_sel_t wr_sel;
	coproc_sel_t rd_sel;       // Selector of the read in flight
	logic        rd_coproc;    // Address bit 12 of the read in flight
	logic        step;
	logic [31:0] ctrl_p1, ctrl_p2;
	logic [31:0] size_p1, size_p2;
	logic [31:0] pos_p1, pos_p2;
	logic [3:0]  coll_p1, coll_p2;
	logic [31:0] attack_p1, attack_p2;
	logic [31:0] knock_p1, knock_p2;
	logic [31:0] damage_p1, damage_p2;
	logic [31:0] mem_q;
	logic [31:0] coproc_rdata;

	assign wr_sel = coproc_sel_t'(address[11:7]);

	data_memory #(.DMEM_ADDR_BITS(DMEM_ADDR_BITS)) dmem (
		.clock(clock), .address(address[DMEM_ADDR_BITS-1:0]), .data(data_in),
		.wren(wren && !address[12]), .q(mem_q)
	);

	always_ff @(posedge clock) begin
		if (reset) begin
			ctrl_p1 <= '0;
			ctrl_p2 <= '0;
			size_p1 <= '0;
			size_p2 <= '0;
			step <= 1'b0;
			rd_coproc <= 1'b1;
			rd_sel <= SEL_STEP; // Reads as zero until the first access
		end else begin
			step <= 1'b0;
			rd_coproc <= address[12];
			rd_sel <= wr_sel;
			if (wren && address[12]) begin
				case (wr_sel)
					SEL_CTRL_P1: ctrl_p1 <= data_in;
					SEL_CTRL_P2: ctrl_p2 <= data_in;
					SEL_SIZE_P1: size_p1 <= data_in;
					SEL_SIZE_P2: size_p2 <= data_in;
					SEL_STEP:    step <= 1'b1;
					default:     ; // Read-only or unmapped
				endcase
			end
		end
	end

	// Player 1
	physics_unit phys_p1 (
		.clock(clock), .reset(reset), .step(step), .start_pos(START_POS_P1),
		.controls(ctrl_p1), .knockback(knock_p2), .frozen(attack_p1[ATK_FREEZE_BIT]),
		.on_floor(coll_p1[COLL_FLOOR]), .position(pos_p1)
	);
	collision_unit coll_unit_p1 (
		.player_pos(pos_p1), .player_size(size_p1),
		.stage_pos(STAGE_POS), .stage_size(STAGE_SIZE), .coll(coll_p1)
	);
	attack_unit #(.ATTACK_STEPS(ATTACK_STEPS)) atk_p1 (
		.clock(clock), .reset(reset), .step(step), .controls(ctrl_p1),
		.own_pos(pos_p1), .own_size(size_p1), .foe_pos(pos_p2), .foe_size(size_p2),
		.attack(attack_p1), .knockback(knock_p1)
	);
	damage_unit dmg_p1 (
		.clock(clock), .reset(reset), .hit(attack_p2[ATK_HIT_BIT]), .damage(damage_p1)
	);

	// Player 2
	physics_unit phys_p2 (
		.clock(clock), .reset(reset), .step(step), .start_pos(START_POS_P2),
		.controls(ctrl_p2), .knockback(knock_p1), .frozen(attack_p2[ATK_FREEZE_BIT]),
		.on_floor(coll_p2[COLL_FLOOR]), .position(pos_p2)
	);
	collision_unit coll_unit_p2 (
		.player_pos(pos_p2), .player_size(size_p2),
		.stage_pos(STAGE_POS), .stage_size(STAGE_SIZE), .coll(coll_p2)
	);
	attack_unit #(.ATTACK_STEPS(ATTACK_STEPS)) atk_p2 (
		.clock(clock), .reset(reset), .step(step), .controls(ctrl_p2),
		.own_pos(pos_p2), .own_size(size_p2), .foe_pos(pos_p1), .foe_size(size_p1),
		.attack(attack_p2), .knockback(knock_p2)
	);
	damage_unit dmg_p2 (
		.clock(clock), .reset(reset), .hit(attack_p1[ATK_HIT_BIT]), .damage(damage_p2)
	);

	// Live values so a read after a step sees the new state
	always_comb begin
		case (rd_sel)
			SEL_POS_P1:    coproc_rdata = pos_p1;
			SEL_POS_P2:    coproc_rdata = pos_p2;
			SEL_CTRL_P1:   coproc_rdata = ctrl_p1;
			SEL_CTRL_P2:   coproc_rdata = ctrl_p2;
			SEL_SIZE_P1:   coproc_rdata = size_p1;
			SEL_SIZE_P2:   coproc_rdata = size_p2;
			SEL_COLL_P1:   coproc_rdata = {28'b0, coll_p1};
			SEL_COLL_P2:   coproc_rdata = {28'b0, coll_p2};
			SEL_ATTACK_P1: coproc_rdata = attack_p1;
			SEL_ATTACK_P2: coproc_rdata = attack_p2;
			SEL_DAMAGE_P1: coproc_rdata = damage_p1;
			SEL_DAMAGE_P2: coproc_rdata = damage_p2;
			default:       coproc_rdata = 32'd0;
		endcase
	end

	assign data_out = rd_coproc ? coproc_rdata : mem_q;

endmodule

`default_nettype wire

/* testbench/mmio_hub_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mmio_hub_tb import arena_pkg::*; ();

	localparam int MEM_WORDS = 64;
	localparam int MEM_CYCLES = 3 * MEM_WORDS + 4; // Fill plus two readback passes
	localparam int RESET_READ_CYCLES = 4;

	logic        clock;
	logic        reset;
	logic [12:0] address;
	logic [31:0] data_in;
	logic        wren;
	logic [31:0] data_out;

	// Operations loaded from the stimulus file
	logic        op_write[$];
	logic [12:0] op_addr[$];
	logic [31:0] op_data[$];
	logic [31:0] op_expect[$];

	logic [12:0] mem_addr [0:MEM_WORDS-1];
	logic [31:0] mem_word [0:MEM_WORDS-1];

	logic        pend_valid;   // A read is waiting for its data
	logic [12:0] pend_addr;
	logic [31:0] pend_expect;
	bit          stim_opened;
	int          errors;
	int          checks;
	int          cycles = 0;
	int          cycle_limit;

	mmio_hub dut_i (
		.clock(clock), .reset(reset), .address(address), .data_in(data_in),
		.wren(wren), .data_out(data_out)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Test failures found");
			$finish;
		end
	end

	task automatic check_read();
		if (pend_valid) begin
			checks++;
			assert (data_out === pend_expect) else begin
				errors++;
				$display("CHECK FAILED at %0t: addr %h expected %h got %h",
					$time, pend_addr, pend_expect, data_out);
			end
		end
	endtask

	// One bus operation per cycle; the previous read is checked mid-cycle
	task automatic issue_op(input logic write, input logic check, input logic [12:0] addr,
			input logic [31:0] wdata, input logic [31:0] expected);
		@(posedge clock);
		address <= addr;
		data_in <= wdata;
		wren <= write;
		@(negedge clock);
		check_read();
		pend_valid = check && !write;
		pend_addr = addr;
		pend_expect = expected;
	endtask

	task automatic idle_cycle();
		issue_op(1'b0, 1'b0, 13'h1f80, 32'd0, 32'd0);
	endtask

	task automatic load_stimulus(output bit opened);
		int          fd;
		int          n;
		int          ch;
		logic [7:0]  kind;
		logic [12:0] a;
		logic [31:0] d;
		logic [31:0] e;
		fd = $fopen("testbench/mmio_stimulus.txt", "r");
		opened = (fd != 0);
		if (opened) begin
			while (!$feof(fd)) begin
				n = $fscanf(fd, " %c", kind);
				if (n == 1 && kind == "#") begin
					ch = $fgetc(fd); // Skip the rest of a comment line
					while (ch != 10 && ch != -1) begin
						ch = $fgetc(fd);
					end
				end else if (n == 1) begin
					n = $fscanf(fd, " %h %h %h", a, d, e);
					op_write.push_back(kind == "W");
					op_addr.push_back(a);
					op_data.push_back(d);
					op_expect.push_back(e);
				end
			end
			$fclose(fd);
		end
	endtask

	// Status words that come out of reset at zero
	task automatic check_reset_reads();
		issue_op(1'b0, 1'b1, {1'b1, SEL_COLL_P2, 7'd0}, 32'd0, 32'd0);
		issue_op(1'b0, 1'b1, {1'b1, SEL_ATTACK_P2, 7'd0}, 32'd0, 32'd0);
		issue_op(1'b0, 1'b1, {1'b1, SEL_DAMAGE_P1, 7'd0}, 32'd0, 32'd0);
		idle_cycle();
	endtask

	task automatic fill_memory();
		for (int i = 0; i < MEM_WORDS; i++) begin
			// Every fourth word lands on the low bits of a hub register address
			if (i % 4 == 0) begin
				mem_addr[i] = 13'(i * 64);
			end else begin
				mem_addr[i] = 13'(i * 64 + int'($urandom % 64));
			end
			mem_word[i] = $urandom;
			issue_op(1'b1, 1'b0, mem_addr[i], mem_word[i], 32'd0);
		end
	endtask

	task automatic verify_memory();
		for (int i = 0; i < MEM_WORDS; i++) begin
			issue_op(1'b0, 1'b1, mem_addr[i], 32'd0, mem_word[i]);
		end
		idle_cycle();
	endtask

	task automatic run_file_ops();
		for (int i = 0; i < op_write.size(); i++) begin
			issue_op(op_write[i], 1'b1, op_addr[i], op_data[i], op_expect[i]);
		end
		idle_cycle();
	endtask

	initial begin
		reset = 1'b1;
		address = '0;
		data_in = '0;
		wren = 1'b0;
		errors = 0;
		checks = 0;
		cycle_limit = 0;
		pend_valid = 1'b0;
		pend_addr = '0;
		pend_expect = '0;
		void'($urandom(32'h38dc_7e26));
		load_stimulus(stim_opened);
		if (!stim_opened) begin
			$display("Cannot open the stimulus file testbench/mmio_stimulus.txt");
			errors++;
		end else begin
			cycle_limit = 2 * op_write.size() + 100 + MEM_CYCLES + RESET_READ_CYCLES;
			repeat (4) @(posedge clock);
			reset <= 1'b0;
			check_reset_reads();
			fill_memory();
			verify_memory();
			run_file_ops();
			verify_memory(); // Hub traffic must leave memory alone
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/mmio_stimulus.txt */
# kind address write_data expected, all hex; W writes, R reads and compares
# expected is unused on writes
R 1000 00000000 00640096
R 1080 00000000 012C0096
R 1600 00000000 00000000
R 1800 00000000 00000000
R 1980 00000000 00000000
W 1400 00140028 00000000
W 1480 00140028 00000000
W 1200 00000002 00000000
W 1280 00000001 00000000
W 1C00 00000001 00000000
R 1000 00000000 00680097
R 1080 00000000 01280097
W 1C00 00000001 00000000
W 1C00 00000001 00000000
W 1C00 00000001 00000000
R 1000 00000000 007400A0
R 1080 00000000 011C00A0
R 1600 00000000 00000001
W 1C00 00000001 00000000
R 1000 00000000 007800A0
W 1200 00000004 00000000
W 1C00 00000001 00000000
R 1000 00000000 00780098
W 1C00 00000001 00000000
R 1000 00000000 00780091
R 1080 00000000 011000A0
W 1200 00000000 00000000
W 1280 00000000 00000000
W 1400 00C80028 00000000
W 1200 00000008 00000000
W 1C00 00000001 00000000
R 1800 00000000 00000801
R 1000 00000000 0078008B
R 1980 00000000 00000007
W 1200 00000000 00000000
W 1C00 00000001 00000000
W 1C00 00000001 00000000
W 1C00 00000001 00000000
R 1800 00000000 00000000
R 1080 00000000 012200A0
R 1000 00000000 0078008B
W 1C00 00000001 00000000
R 1980 00000000 00000007
R 1000 00000000 00780086
W 1200 00000008 00000000
W 1C00 00000001 00000000
W 1200 00000000 00000000
R 1980 00000000 0000000E
R 1900 00000000 00000000
W 1000 DEADBEEF 00000000
R 1000 00000000 00780082
W 1980 12345678 00000000
R 1980 00000000 0000000E
W 1F80 ABCDEF01 00000000
R 1F80 00000000 00000000
W 1480 00140064 00000000
R 1680 00000000 00000003

/* filelist.f */
source/arena_pkg.sv
source/data_memory.sv
source/physics_unit.sv
source/collision_unit.sv
source/attack_unit.sv
source/damage_unit.sv
source/mmio_hub.sv
testbench/mmio_hub_tb.sv

/* run.sh */
#!/bin/sh
# Build the MMIO hub testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal -f filelist.f \
	--top-module mmio_hub_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vmmio_hub_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qF "All tests passed!"; then
	exit 0
else
	exit 1
fi
